// ==== common/cache_pkg.sv ====
// --------------------------------------
// Widths fixed at 32-bit words in 128-bit lines
// Index width follows num_sets in each module
// --------------------------------------

package cache_pkg;

  localparam int addr_w         = 32;
  localparam int word_w         = 32;
  localparam int line_w         = 128;
  localparam int words_per_line = line_w / word_w;

  // Address field positions
  localparam int offset_lsb = 2;
  localparam int offset_w   = $clog2(words_per_line);
  localparam int index_lsb  = offset_lsb + offset_w;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [word_w-1:0] word_t;
  typedef logic [line_w-1:0] line_t;

  // Memory requests use only op_read and op_write
  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_init  = 2'd2
  } mem_op_e;

  // Word offset within the line
  function automatic logic [offset_w-1:0] word_offset(addr_t addr);
    return addr[offset_lsb +: offset_w];
  endfunction

  // Line-aligned address
  function automatic addr_t line_addr(addr_t addr);
    return {addr[addr_w-1:index_lsb], {index_lsb{1'b0}}};
  endfunction

endpackage

// ==== cache_ctrl/cache_meta.sv ====
// --------------------------------------
// Valid, dirty and LRU state per set
// Reads are combinational, writes land on the next edge
// --------------------------------------

module cache_meta #(
  parameter int num_sets = 8,
  localparam int idx_w = $clog2(num_sets)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [idx_w-1:0] idx,
  input  logic             way_sel,
  input  logic             valid_wen,
  input  logic             dirty_wen,
  input  logic             dirty_in,
  input  logic             lru_wen,
  output logic [1:0]       is_valid,
  output logic [1:0]       is_dirty,
  output logic             lru_way
);

  logic [1:0][num_sets-1:0] valid_q;
  logic [1:0][num_sets-1:0] dirty_q;
  logic [num_sets-1:0]      lru_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      // A valid write only ever installs a line
      if (valid_wen) begin
        valid_q[way_sel][idx] <= 1'b1;
      end
      if (dirty_wen) begin
        dirty_q[way_sel][idx] <= dirty_in;
      end
      // Least recently used is the way not touched
      if (lru_wen) begin
        lru_q[idx] <= ~way_sel;
      end
    end
  end

  assign is_valid = {valid_q[1][idx], valid_q[0][idx]};
  assign is_dirty = {dirty_q[1][idx], dirty_q[0][idx]};
  assign lru_way  = lru_q[idx];

endmodule

// ==== cache_ctrl/cache_ctrl.sv ====
// --------------------------------------
// One transaction at a time, cachereq_rdy only in idle
// Way is fixed in tag_check for the rest of the request
// --------------------------------------

module cache_ctrl
  import cache_pkg::*;
#(
  parameter int num_sets = 8,
  localparam int idx_w = $clog2(num_sets)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cachereq_val,
  output logic             cachereq_rdy,
  output logic             cacheresp_val,
  input  logic             cacheresp_rdy,
  output logic             memreq_val,
  input  logic             memreq_rdy,
  output mem_op_e          memreq_type,
  input  logic             memresp_val,
  output logic             memresp_rdy,
  input  mem_op_e          req_type,
  input  logic [idx_w-1:0] req_idx,
  input  logic [1:0]       tag_match,
  output logic             req_en,
  output logic             refill_en,
  output logic             tag_wen,
  output logic             data_wen,
  output logic             read_en,
  output logic             victim_en,
  output logic             is_refill,
  output logic             way_sel
);

  typedef enum logic [3:0] {
    idle, tag_check, read_access, write_access, init_access,
    refill_request, refill_wait, refill_update,
    evict_prepare, evict_request, evict_wait, resp_wait
  } state_e;

  state_e state_q;
  state_e state_next;

  logic [1:0] is_valid;
  logic [1:0] is_dirty;
  logic       lru_way;
  logic       valid_wen;
  logic       dirty_wen;
  logic       dirty_in;
  logic       lru_wen;
  logic [1:0] hit;
  logic       any_hit;
  logic       victim_dirty;
  logic       way_next;

  cache_meta #(.num_sets(num_sets)) u_meta (
    .clk       (clk),
    .reset     (reset),
    .idx       (req_idx),
    .way_sel   (way_sel),
    .valid_wen (valid_wen),
    .dirty_wen (dirty_wen),
    .dirty_in  (dirty_in),
    .lru_wen   (lru_wen),
    .is_valid  (is_valid),
    .is_dirty  (is_dirty),
    .lru_way   (lru_way)
  );

  // --------------------------------------
  // Hit and victim decision
  // --------------------------------------

  assign hit          = is_valid & tag_match;
  assign any_hit      = |hit;
  assign victim_dirty = is_dirty[lru_way];
  // Miss falls back to the LRU way
  assign way_next     = any_hit ? hit[1] : lru_way;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= idle;
      way_sel <= 1'b0;
    end else begin
      state_q <= state_next;
      if (state_q == tag_check) begin
        way_sel <= way_next;
      end
    end
  end

  // --------------------------------------
  // Next state
  // --------------------------------------

  always_comb begin
    state_next = state_q;
    case (state_q)
      idle: if (cachereq_val && cachereq_rdy) state_next = tag_check;
      tag_check: begin
        if (req_type == op_init && (any_hit || !victim_dirty)) state_next = init_access;
        else if (any_hit && req_type == op_read) state_next = read_access;
        else if (any_hit) state_next = write_access;
        else if (!victim_dirty) state_next = refill_request;
        else state_next = evict_prepare;
      end
      read_access, write_access, init_access: state_next = resp_wait;
      refill_request: if (memreq_rdy) state_next = refill_wait;
      refill_wait: if (memresp_val) state_next = refill_update;
      refill_update: begin
        state_next = (req_type == op_read) ? read_access : write_access;
      end
      evict_prepare: state_next = evict_request;
      evict_request: if (memreq_rdy) state_next = evict_wait;
      // Init skips the refill once the dirty victim is out
      evict_wait: begin
        if (memresp_val) begin
          state_next = (req_type == op_init) ? init_access : refill_request;
        end
      end
      resp_wait: if (cacheresp_rdy) state_next = idle;
      default: state_next = idle;
    endcase
  end

  // --------------------------------------
  // State outputs
  // --------------------------------------

  always_comb begin
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memreq_type   = op_read;
    memresp_rdy   = 1'b0;
    req_en        = 1'b0;
    refill_en     = 1'b0;
    tag_wen       = 1'b0;
    data_wen      = 1'b0;
    read_en       = 1'b0;
    victim_en     = 1'b0;
    is_refill     = 1'b0;
    valid_wen     = 1'b0;
    dirty_wen     = 1'b0;
    dirty_in      = 1'b0;
    lru_wen       = 1'b0;
    case (state_q)
      idle: begin
        cachereq_rdy = 1'b1;
        req_en       = cachereq_val;
      end
      read_access: begin
        read_en = 1'b1;
        lru_wen = 1'b1;
      end
      write_access: begin
        tag_wen   = 1'b1;
        data_wen  = 1'b1;
        valid_wen = 1'b1;
        dirty_wen = 1'b1;
        dirty_in  = 1'b1;
        lru_wen   = 1'b1;
      end
      // Installed clean, memory never read
      init_access: begin
        tag_wen   = 1'b1;
        data_wen  = 1'b1;
        valid_wen = 1'b1;
        dirty_wen = 1'b1;
        lru_wen   = 1'b1;
      end
      refill_request: begin
        memreq_val = 1'b1;
        is_refill  = 1'b1;
      end
      refill_wait: begin
        memresp_rdy = 1'b1;
        refill_en   = memresp_val;
        is_refill   = 1'b1;
      end
      refill_update: begin
        is_refill = 1'b1;
        tag_wen   = 1'b1;
        data_wen  = 1'b1;
        valid_wen = 1'b1;
        dirty_wen = 1'b1;
      end
      evict_prepare: victim_en = 1'b1;
      evict_request: begin
        memreq_val  = 1'b1;
        memreq_type = op_write;
      end
      evict_wait: memresp_rdy = 1'b1;
      resp_wait: cacheresp_val = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== source/cache_dpath.sv ====
// --------------------------------------
// Tag and data arrays hold no reset value
// An init defines only the written word of its line
// --------------------------------------

module cache_dpath
  import cache_pkg::*;
#(
  parameter int num_sets = 8,
  localparam int idx_w = $clog2(num_sets)
) (
  input  logic             clk,
  input  logic             reset,
  input  mem_op_e          cachereq_type,
  input  addr_t            cachereq_addr,
  input  word_t            cachereq_data,
  output mem_op_e          cacheresp_type,
  output word_t            cacheresp_data,
  output addr_t            memreq_addr,
  output line_t            memreq_data,
  input  line_t            memresp_data,
  input  logic             req_en,
  input  logic             refill_en,
  input  logic             tag_wen,
  input  logic             data_wen,
  input  logic             read_en,
  input  logic             victim_en,
  input  logic             is_refill,
  input  logic             way_sel,
  output mem_op_e          req_type,
  output logic [idx_w-1:0] req_idx,
  output logic [1:0]       tag_match
);

  localparam int tag_w = addr_w - index_lsb - idx_w;

  addr_t                     req_addr_q;
  word_t                     req_data_q;
  line_t                     refill_q;
  line_t                     read_line_q;
  logic [tag_w-1:0]          victim_tag_q;
  logic [tag_w-1:0]          req_tag;
  logic [offset_w-1:0]       req_off;
  logic [words_per_line-1:0] word_wen;
  line_t                     cur_line;
  line_t                     write_line;

  logic [tag_w-1:0] tag_array  [2][num_sets];
  line_t            data_array [2][num_sets];

  // --------------------------------------
  // Request and refill registers
  // --------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      req_type <= op_read;
    end else if (req_en) begin
      req_type <= cachereq_type;
    end
  end

  always_ff @(posedge clk) begin
    if (req_en) begin
      req_addr_q <= cachereq_addr;
      req_data_q <= cachereq_data;
    end
    if (refill_en) begin
      refill_q <= memresp_data;
    end
  end

  assign req_tag = req_addr_q[addr_w-1 -: tag_w];
  assign req_idx = req_addr_q[index_lsb +: idx_w];
  assign req_off = word_offset(req_addr_q);

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      tag_match[w] = (tag_array[w][req_idx] == req_tag);
    end
  end

  // --------------------------------------
  // Array writes
  // --------------------------------------

  assign cur_line = data_array[way_sel][req_idx];

  // Refill takes the whole line, write and init one word
  always_comb begin
    word_wen          = '0;
    word_wen[req_off] = 1'b1;
    if (is_refill) begin
      word_wen = '1;
    end
    write_line = cur_line;
    for (int i = 0; i < words_per_line; i++) begin
      if (word_wen[i]) begin
        write_line[i*word_w +: word_w] = is_refill ? refill_q[i*word_w +: word_w] : req_data_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tag_array[way_sel][req_idx] <= req_tag;
    end
    if (data_wen) begin
      data_array[way_sel][req_idx] <= write_line;
    end
  end

  // Read line doubles as the victim line on eviction
  always_ff @(posedge clk) begin
    if (read_en || victim_en) begin
      read_line_q <= cur_line;
    end
    if (victim_en) begin
      victim_tag_q <= tag_array[way_sel][req_idx];
    end
  end

  // --------------------------------------
  // Response and memory request
  // --------------------------------------

  assign cacheresp_type = req_type;
  assign cacheresp_data = read_line_q[req_off*word_w +: word_w];

  assign memreq_addr = is_refill ? line_addr(req_addr_q)
                                 : {victim_tag_q, req_idx, {index_lsb{1'b0}}};
  assign memreq_data = read_line_q;

endmodule

// ==== source/blocking_cache.sv ====
// --------------------------------------
// Two-way write-back cache, blocking
// num_sets must be a power of two
// --------------------------------------

module blocking_cache
  import cache_pkg::*;
#(
  parameter int num_sets = 8
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    cachereq_val,
  output logic    cachereq_rdy,
  input  mem_op_e cachereq_type,
  input  addr_t   cachereq_addr,
  input  word_t   cachereq_data,
  output logic    cacheresp_val,
  input  logic    cacheresp_rdy,
  output mem_op_e cacheresp_type,
  output word_t   cacheresp_data,
  output logic    memreq_val,
  input  logic    memreq_rdy,
  output mem_op_e memreq_type,
  output addr_t   memreq_addr,
  output line_t   memreq_data,
  input  logic    memresp_val,
  output logic    memresp_rdy,
  input  line_t   memresp_data
);

  localparam int idx_w = $clog2(num_sets);

  // Control to datapath
  logic req_en;
  logic refill_en;
  logic tag_wen;
  logic data_wen;
  logic read_en;
  logic victim_en;
  logic is_refill;
  logic way_sel;

  // Status back to control
  mem_op_e          req_type;
  logic [idx_w-1:0] req_idx;
  logic [1:0]       tag_match;

  cache_ctrl #(.num_sets(num_sets)) u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq_type   (memreq_type),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .req_type      (req_type),
    .req_idx       (req_idx),
    .tag_match     (tag_match),
    .req_en        (req_en),
    .refill_en     (refill_en),
    .tag_wen       (tag_wen),
    .data_wen      (data_wen),
    .read_en       (read_en),
    .victim_en     (victim_en),
    .is_refill     (is_refill),
    .way_sel       (way_sel)
  );

  cache_dpath #(.num_sets(num_sets)) u_dpath (
    .clk            (clk),
    .reset          (reset),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .cacheresp_type (cacheresp_type),
    .cacheresp_data (cacheresp_data),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data),
    .memresp_data   (memresp_data),
    .req_en         (req_en),
    .refill_en      (refill_en),
    .tag_wen        (tag_wen),
    .data_wen       (data_wen),
    .read_en        (read_en),
    .victim_en      (victim_en),
    .is_refill      (is_refill),
    .way_sel        (way_sel),
    .req_type       (req_type),
    .req_idx        (req_idx),
    .tag_match      (tag_match)
  );

endmodule

// ==== dv/tb_mem_model.sv ====
// --------------------------------------
// Line-wide memory, one request at a time
// Answers on the cycle after each accepted request, writes included
// --------------------------------------

module tb_mem_model
  import cache_pkg::*;
#(
  parameter int num_lines = 64
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    memreq_val,
  input  logic    memreq_rdy,
  input  mem_op_e memreq_type,
  input  addr_t   memreq_addr,
  input  line_t   memreq_data,
  output logic    memresp_val,
  input  logic    memresp_rdy,
  output line_t   memresp_data
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int line_idx_w = $clog2(num_lines);

  // Contents are loaded by the testbench before reset ends
  line_t store   [num_lines];
  logic  written [num_lines];

  logic                  take_req;
  logic                  take_resp;
  mem_op_e               req_type;
  logic [line_idx_w-1:0] req_line;
  line_t                 req_data;

  initial begin
    memresp_val  = 1'b0;
    memresp_data = '0;
    for (int i = 0; i < num_lines; i++) begin
      written[i] = 1'b0;
    end
    forever begin
      // Handshakes are stable at the falling edge
      @(negedge clk);
      take_req  = memreq_val && memreq_rdy;
      take_resp = memresp_val && memresp_rdy;
      req_type  = memreq_type;
      req_line  = memreq_addr[index_lsb +: line_idx_w];
      req_data  = memreq_data;
      @(posedge clk);
      #1;
      if (reset || take_resp) begin
        memresp_val = 1'b0;
      end
      if (take_req && !reset) begin
        if (req_type == op_write) begin
          store[req_line]   = req_data;
          written[req_line] = 1'b1;
          memresp_data      = '0;
        end else begin
          memresp_data = store[req_line];
        end
        memresp_val = 1'b1;
      end
    end
  end

endmodule

// ==== dv/tb_blocking_cache.sv ====
// --------------------------------------
// Random reads and writes over a few conflicting lines
// Stops at the first mismatch or timeout
// --------------------------------------

module tb_blocking_cache
  import cache_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_sets   = 8;
  localparam int num_lines  = 64;
  localparam int line_bits  = $clog2(num_lines);
  localparam int tag_lsb    = index_lsb + $clog2(num_sets);
  localparam int timeout    = 200;
  localparam int num_random = 300;

  // Offset bits and set bits of an address
  localparam addr_t off_mask = addr_t'((1 << index_lsb) - 1);
  localparam addr_t set_mask = addr_t'((1 << tag_lsb) - (1 << index_lsb));

  logic    clk;
  logic    reset;
  logic    cachereq_val;
  logic    cachereq_rdy;
  mem_op_e cachereq_type;
  addr_t   cachereq_addr;
  word_t   cachereq_data;
  logic    cacheresp_val;
  logic    cacheresp_rdy;
  mem_op_e cacheresp_type;
  word_t   cacheresp_data;
  logic    memreq_val;
  logic    memreq_rdy;
  mem_op_e memreq_type;
  addr_t   memreq_addr;
  line_t   memreq_data;
  logic    memresp_val;
  logic    memresp_rdy;
  line_t   memresp_data;

  // Reference word store, one entry per memory word
  word_t ref_words [num_lines][words_per_line];

  int    mem_reads   = 0;
  int    mem_writes  = 0;
  int    accepted    = 0;
  int    responded   = 0;
  logic  mem_pending = 1'b0;
  addr_t cur_addr    = '0;

  blocking_cache #(.num_sets(num_sets)) u_dut (.*);

  tb_mem_model #(.num_lines(num_lines)) u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Back-pressure on responses and memory requests
  initial begin
    memreq_rdy    = 1'b0;
    cacheresp_rdy = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      memreq_rdy    = ($urandom % 2) == 0;
      cacheresp_rdy = ($urandom % 4) != 0;
    end
  end

  // --------------------------------------
  // Checks
  // --------------------------------------

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_addr(string name, addr_t expected, addr_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_op(string name, mem_op_e expected, mem_op_e actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %s got %s", $time, name, expected.name(),
               actual.name());
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_count(string name, int expected, int actual);
    if (actual != expected) begin
      $display("FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic timeout_stop(string what);
    $display("Timeout: no %s within %0d cycles at %0t", what, timeout, $time);
    abort_run();
  endtask

  // Memory traffic and handshake counts, sampled mid-cycle
  always @(negedge clk) begin
    // Memory response is awaited from request handshake to response handshake
    if (!reset) begin
      check_bit("memresp_rdy", mem_pending, memresp_rdy);
    end
    if (!reset && memresp_val && memresp_rdy) begin
      mem_pending = 1'b0;
    end
    if (!reset && memreq_val && memreq_rdy) begin
      mem_pending = 1'b1;
      if (memreq_type == op_write) begin
        mem_writes++;
        check_addr("memreq_addr", cur_addr & set_mask, memreq_addr & (set_mask | off_mask));
        for (int w = 0; w < words_per_line; w++) begin
          check_word("memreq_data", ref_words[memreq_addr[index_lsb +: line_bits]][w],
                     memreq_data[w*word_w +: word_w]);
        end
      end else begin
        mem_reads++;
        check_addr("memreq_addr", cur_addr & ~off_mask, memreq_addr);
      end
    end
    if (!reset && cachereq_val && cachereq_rdy) begin
      accepted++;
    end
    if (!reset && cacheresp_val && cacheresp_rdy) begin
      responded++;
    end
  end

  // --------------------------------------
  // Requests
  // --------------------------------------

  function automatic addr_t make_addr(int tag, int set_idx, int off);
    return addr_t'((tag << tag_lsb) | (set_idx << index_lsb) | (off << offset_lsb));
  endfunction

  task automatic run_request(mem_op_e op, addr_t addr, word_t data);
    int                    cycles;
    word_t                 expected;
    logic [line_bits-1:0]  ln_idx;
    logic [offset_w-1:0]   wd_idx;
    ln_idx        = addr[index_lsb +: line_bits];
    wd_idx        = addr[offset_lsb +: offset_w];
    cur_addr      = addr;
    cachereq_val  = 1'b1;
    cachereq_type = op;
    cachereq_addr = addr;
    cachereq_data = data;
    cycles        = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout) timeout_stop("request accept");
    end while (!cachereq_rdy);
    @(posedge clk);
    #1;
    cachereq_val = 1'b0;
    expected     = ref_words[ln_idx][wd_idx];
    if (op != op_read) begin
      ref_words[ln_idx][wd_idx] = data;
    end
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout) timeout_stop("cache response");
    end while (!(cacheresp_val && cacheresp_rdy));
    check_op("cacheresp_type", op, cacheresp_type);
    if (op == op_read) begin
      check_word("cacheresp_data", expected, cacheresp_data);
    end
    @(posedge clk);
    #1;
  endtask

  // Request with a known count of memory reads and writes
  task automatic traffic_request(mem_op_e op, addr_t addr, word_t data, int reads,
                                 int writes);
    int reads_before;
    int writes_before;
    reads_before  = mem_reads;
    writes_before = mem_writes;
    run_request(op, addr, data);
    check_count("memory reads", reads, mem_reads - reads_before);
    check_count("memory writes", writes, mem_writes - writes_before);
  endtask

  // --------------------------------------
  // Test sequence
  // --------------------------------------

  initial begin
    line_t   fill;
    int      tag;
    int      set_idx;
    int      off;
    mem_op_e op;
    word_t   data;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = op_read;
    cachereq_addr = '0;
    cachereq_data = '0;
    void'($urandom(29369));
    for (int i = 0; i < num_lines; i++) begin
      for (int w = 0; w < words_per_line; w++) begin
        ref_words[i][w]           = $urandom;
        fill[w*word_w +: word_w] = ref_words[i][w];
      end
      u_mem.store[i] = fill;
    end

    repeat (16) begin
      @(negedge clk);
      check_bit("cacheresp_val", 1'b0, cacheresp_val);
      check_bit("memreq_val", 1'b0, memreq_val);
      check_bit("memresp_rdy", 1'b0, memresp_rdy);
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_bit("cachereq_rdy", 1'b1, cachereq_rdy);
    check_bit("cacheresp_val", 1'b0, cacheresp_val);
    check_bit("memreq_val", 1'b0, memreq_val);
    check_bit("memresp_rdy", 1'b0, memresp_rdy);
    @(posedge clk);
    #1;

    // A then B in set 2, touch A, then C replaces B
    traffic_request(op_read, make_addr(0, 2, 0), '0, 1, 0);
    traffic_request(op_read, make_addr(1, 2, 1), '0, 1, 0);
    traffic_request(op_read, make_addr(0, 2, 2), '0, 0, 0);
    traffic_request(op_read, make_addr(2, 2, 3), '0, 1, 0);
    traffic_request(op_read, make_addr(0, 2, 1), '0, 0, 0);
    traffic_request(op_read, make_addr(1, 2, 0), '0, 1, 0);

    // Two dirty lines in set 3, then an init evicts the older one
    traffic_request(op_write, make_addr(0, 3, 1), $urandom, 1, 0);
    traffic_request(op_write, make_addr(1, 3, 2), $urandom, 1, 0);
    traffic_request(op_init, make_addr(2, 3, 0), $urandom, 0, 1);
    traffic_request(op_read, make_addr(2, 3, 0), '0, 0, 0);
    // Empty set 4 has a clean victim
    traffic_request(op_init, make_addr(0, 4, 3), $urandom, 0, 0);
    traffic_request(op_read, make_addr(0, 4, 3), '0, 0, 0);

    // Three tags over sets 0 and 1
    for (int n = 0; n < num_random; n++) begin
      tag     = $urandom % 3;
      set_idx = $urandom % 2;
      off     = $urandom % 4;
      op      = (($urandom % 2) == 0) ? op_read : op_write;
      data    = $urandom;
      run_request(op, make_addr(tag, set_idx, off), data);
    end

    // Two fresh tags per set push every dirty line out
    for (int s = 0; s < 4; s++) begin
      run_request(op_read, make_addr(4, s, 0), '0);
      run_request(op_read, make_addr(5, s, 0), '0);
    end

    for (int i = 0; i < num_lines; i++) begin
      if (u_mem.written[i]) begin
        for (int w = 0; w < words_per_line; w++) begin
          check_word($sformatf("memory line %0d word %0d", i, w), ref_words[i][w],
                     u_mem.store[i][w*word_w +: word_w]);
        end
      end
    end
    check_count("cache responses", accepted, responded);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== blocking_cache.f ====
common/cache_pkg.sv
cache_ctrl/cache_meta.sv
cache_ctrl/cache_ctrl.sv
source/cache_dpath.sv
source/blocking_cache.sv
dv/tb_mem_model.sv
dv/tb_blocking_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_blocking_cache \
  -f blocking_cache.f -o sim_tb
# The simulator exits non-zero on failure, the log still decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -qx "PASS: all tests" sim.log; then
  exit 0
fi
exit 1
